//--- Makefile
# Verilator build and run for the switch_qm testbench

VERILATOR ?= verilator
TOP       ?= tb_switch_qm
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^Result: PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- qm_checker.sv
////////////////////////////////////////
// queue manager checker
// per-group reference model, selection
// function and output comparison
////////////////////////////////////////

`timescale 1ns/1ns

module qm_checker import qm_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [time_width-1:0]  local_clock,
    input  logic                   in_valid,
    input  logic                   in_ready,
    input  logic [group_width-1:0] in_group_id,
    input  logic [md_width-1:0]    in_metadata,
    input  logic [time_width-1:0]  in_elig_time,
    input  logic                   out_valid,
    input  logic                   out_ready,
    input  logic [md_width-1:0]    out_metadata,
    input  logic [group_width-1:0] out_group_id,
    output int                     errors,
    output int                     outputs_seen,
    output int                     pending
);

    localparam int model_depth = 32;   // store, in flight and output buffer

    logic [md_width-1:0]    mdl_md   [num_groups][model_depth];
    logic [time_width-1:0]  mdl_time [num_groups][model_depth];
    int                     mdl_rd   [num_groups];
    int                     mdl_cnt  [num_groups];
    logic                   was_stalled;
    logic [md_width-1:0]    stall_md;
    logic [group_width-1:0] stall_grp;

    // earliest eligible head per class, highest class first
    function automatic int expected_group(input logic [time_width-1:0] now);
        int best;
        int g;
        best = -1;
        for (int c = num_classes - 1; c >= 0 && best < 0; c--) begin
            for (int k = 0; k < groups_per_class; k++) begin
                g = c + k * num_classes;
                if (mdl_cnt[g] > 0 && mdl_time[g][mdl_rd[g]] <= now &&
                    (best < 0 || mdl_time[g][mdl_rd[g]] < mdl_time[best][mdl_rd[best]]))
                    best = g;   // strict less keeps the lower group on a tie
            end
        end
        return best;
    endfunction

    always @(posedge clk) begin : compare
        int g;
        int wr;
        if (reset) begin
            for (int i = 0; i < num_groups; i++) begin
                mdl_rd[i]  = 0;
                mdl_cnt[i] = 0;
            end
            errors       = 0;
            outputs_seen = 0;
            pending      = 0;
            was_stalled  = 1'b0;
        end else begin
            if (was_stalled && (!out_valid || out_metadata != stall_md ||
                                out_group_id != stall_grp)) begin
                $display("FAIL %0t: output changed while stalled", $time);
                errors++;
            end
            if (out_valid && out_ready) begin
                g = expected_group(local_clock);
                outputs_seen++;
                if (g < 0) begin
                    $display("FAIL %0t: unexpected output group %0d metadata %05h",
                             $time, out_group_id, out_metadata);
                    errors++;
                end else begin
                    if (out_group_id != group_width'(g) ||
                        out_metadata != mdl_md[g][mdl_rd[g]]) begin
                        $display("FAIL %0t: expected group %0d metadata %05h, got %0d %05h",
                                 $time, g, mdl_md[g][mdl_rd[g]], out_group_id, out_metadata);
                        errors++;
                    end
                    mdl_rd[g] = (mdl_rd[g] + 1) % model_depth;   // drop the predicted one
                    mdl_cnt[g]--;
                    pending--;
                end
            end
            if (in_valid && in_ready && in_group_id < group_width'(num_groups)) begin
                g  = int'(in_group_id);
                wr = (mdl_rd[g] + mdl_cnt[g]) % model_depth;
                mdl_md[g][wr]   = in_metadata;
                mdl_time[g][wr] = in_elig_time;
                mdl_cnt[g]++;
                pending++;
            end
            was_stalled = out_valid && !out_ready;
            stall_md    = out_metadata;
            stall_grp   = out_group_id;
        end
    end

endmodule

//--- qm_eligibility_sched.sv
////////////////////////////////////////
// eligibility scheduler
// earliest eligible head per class, then
// strict priority across classes
////////////////////////////////////////

`timescale 1ns/1ns

module qm_eligibility_sched import qm_pkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [time_width-1:0]                 local_clock,
    input  logic [num_groups-1:0]                 head_valid,
    input  logic [num_groups-1:0][md_width-1:0]   head_metadata,
    input  logic [num_groups-1:0][time_width-1:0] head_time,
    input  logic                                  space_ok,
    output logic                                  pop_en,
    output logic [group_width-1:0]                pop_group,
    output logic                                  push_en,
    output logic [md_width-1:0]                   push_metadata,
    output logic [group_width-1:0]                push_group
);

    logic [num_classes-1:0]                                cls_found;
    logic [num_classes-1:0][$clog2(groups_per_class)-1:0]  cls_slot;
    logic [num_classes-1:0][time_width-1:0]                cls_time;
    logic                                                  sel_valid;
    logic [class_width-1:0]                                sel_class;
    logic [group_width-1:0]                                sel_group;

    ////////////////////////////////////////
    // per class earliest eligible head
    ////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < num_classes; c++) begin
            cls_found[c] = 1'b0;
            cls_slot[c]  = '0;
            cls_time[c]  = '0;
            // ascending slot so a tie stays with the lower group
            for (int k = 0; k < groups_per_class; k++) begin
                if (head_valid[c + k * num_classes] &&
                    head_time[c + k * num_classes] <= local_clock &&
                    (!cls_found[c] || head_time[c + k * num_classes] < cls_time[c])) begin
                    cls_found[c] = 1'b1;
                    cls_slot[c]  = k[$clog2(groups_per_class)-1:0];
                    cls_time[c]  = head_time[c + k * num_classes];
                end
            end
        end
    end

    // strict priority, highest class with a candidate wins
    always_comb begin
        sel_valid = 1'b0;
        sel_class = '0;
        for (int c = 0; c < num_classes; c++) begin
            if (cls_found[c]) begin
                sel_valid = 1'b1;
                sel_class = c[class_width-1:0];   // later class overrides
            end
        end
        sel_group = group_width'(sel_class) +
                    group_width'(cls_slot[sel_class]) * group_width'(num_classes);
    end

    ////////////////////////////////////////
    // pop and push issue
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pop_en  <= 1'b0;
            push_en <= 1'b0;
        end else begin
            pop_en  <= sel_valid && space_ok && !pop_en;   // skip cycle after a pop
            push_en <= sel_valid && space_ok && !pop_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid && space_ok && !pop_en) begin
            pop_group     <= sel_group;
            push_group    <= sel_group;
            push_metadata <= head_metadata[sel_group];
        end
    end

    // pushed metadata still matches the head being removed
    a_pop_push_pair: assert property (
        @(posedge clk) disable iff (reset)
        pop_en |-> push_en && push_metadata == head_metadata[pop_group]
    ) else $error("pushed metadata differs from popped head of group %0d", pop_group);

endmodule

//--- qm_enqueue_decode.sv
////////////////////////////////////////
// enqueue decoder
// input handshake, group range check and
// one-cycle write strobe to the group store
////////////////////////////////////////

`timescale 1ns/1ns

module qm_enqueue_decode import qm_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [group_width-1:0] in_group_id,
    input  logic [md_width-1:0]    in_metadata,
    input  logic [time_width-1:0]  in_elig_time,
    input  logic [num_groups-1:0]  group_full,
    output logic                   in_ready,
    output logic                   wr_en,
    output logic [group_width-1:0] wr_group,
    output logic [md_width-1:0]    wr_metadata,
    output logic [time_width-1:0]  wr_time
);

    logic accept_en;    // opens one cycle after reset
    logic in_range;     // group number below num_groups
    logic in_flight;    // write to this group not yet in the store

    assign in_range  = in_group_id < group_width'(num_groups);
    assign in_flight = wr_en && (wr_group == in_group_id);

    // bad group numbers are taken and dropped
    assign in_ready = accept_en &&
                      (!in_range || (!group_full[in_group_id] && !in_flight));

    always_ff @(posedge clk) begin
        if (reset) begin
            accept_en <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            wr_en     <= in_valid && in_ready && in_range;   // drop out of range
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            wr_group    <= in_group_id;
            wr_metadata <= in_metadata;
            wr_time     <= in_elig_time;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the in-flight block keeps the store from overflowing
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !group_full[wr_group]
    ) else $error("write strobe for full group %0d", wr_group);

endmodule

//--- qm_group_store.sv
////////////////////////////////////////
// group store
// twelve circular descriptor fifos with
// head outputs, write and pop ports
////////////////////////////////////////

`timescale 1ns/1ns

module qm_group_store import qm_pkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  wr_en,
    input  logic [group_width-1:0]                wr_group,
    input  logic [md_width-1:0]                   wr_metadata,
    input  logic [time_width-1:0]                 wr_time,
    input  logic                                  pop_en,
    input  logic [group_width-1:0]                pop_group,
    output logic [num_groups-1:0]                 group_full,
    output logic [num_groups-1:0]                 head_valid,
    output logic [num_groups-1:0][md_width-1:0]   head_metadata,
    output logic [num_groups-1:0][time_width-1:0] head_time
);

    logic [md_width-1:0]            md_mem   [num_groups][group_depth];
    logic [time_width-1:0]          time_mem [num_groups][group_depth];
    logic [$clog2(group_depth)-1:0] rd_ptr   [num_groups];
    logic [$clog2(group_depth)-1:0] wr_ptr   [num_groups];
    logic [count_width-1:0]         count    [num_groups];
    logic [num_groups-1:0]          wr_hit;
    logic [num_groups-1:0]          pop_hit;

    always_comb begin
        for (int g = 0; g < num_groups; g++) begin
            wr_hit[g]  = wr_en && (wr_group == group_width'(g));
            pop_hit[g] = pop_en && (pop_group == group_width'(g));
        end
    end

    ////////////////////////////////////////
    // descriptor memory
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            md_mem[wr_group][wr_ptr[wr_group]]   <= wr_metadata;
            time_mem[wr_group][wr_ptr[wr_group]] <= wr_time;
        end
    end

    ////////////////////////////////////////
    // pointers and fill counts
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int g = 0; g < num_groups; g++) begin
                rd_ptr[g] <= '0;
                wr_ptr[g] <= '0;
                count[g]  <= '0;
            end
        end else begin
            for (int g = 0; g < num_groups; g++) begin
                if (wr_hit[g])
                    wr_ptr[g] <= wr_ptr[g] + 1'b1;   // wraps at depth
                if (pop_hit[g])
                    rd_ptr[g] <= rd_ptr[g] + 1'b1;
                case ({wr_hit[g], pop_hit[g]})
                    2'b10:   count[g] <= count[g] + 1'b1;
                    2'b01:   count[g] <= count[g] - 1'b1;
                    default: count[g] <= count[g];   // both or neither
                endcase
            end
        end
    end

    always_comb begin
        for (int g = 0; g < num_groups; g++) begin
            group_full[g]    = count[g] == count_width'(group_depth);
            head_valid[g]    = count[g] != '0;
            head_metadata[g] = md_mem[g][rd_ptr[g]];
            head_time[g]     = time_mem[g][rd_ptr[g]];
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        pop_en |-> head_valid[pop_group]
    ) else $error("pop of empty group %0d", pop_group);

    a_no_write_full: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !group_full[wr_group]
    ) else $error("write to full group %0d", wr_group);

endmodule

//--- qm_output_stage.sv
////////////////////////////////////////
// output stage
// two-entry buffer, valid/ready to consumer
////////////////////////////////////////

`timescale 1ns/1ns

module qm_output_stage import qm_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push_en,
    input  logic [md_width-1:0]    push_metadata,
    input  logic [group_width-1:0] push_group,
    input  logic                   out_ready,
    output logic                   space_ok,
    output logic                   out_valid,
    output logic [md_width-1:0]    out_metadata,
    output logic [group_width-1:0] out_group_id
);

    logic [md_width-1:0]    md_buf  [2];
    logic [group_width-1:0] grp_buf [2];
    logic                   rd_ptr;
    logic                   wr_ptr;
    logic [1:0]             count;
    logic                   pop;

    assign pop          = out_valid && out_ready;
    assign out_valid    = count != 2'd0;
    assign space_ok     = count != 2'd2;
    assign out_metadata = md_buf[rd_ptr];
    assign out_group_id = grp_buf[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_en) begin
            md_buf[wr_ptr]  <= push_metadata;
            grp_buf[wr_ptr] <= push_group;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push_en)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push_en} - {1'b0, pop};
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        push_en |-> space_ok
    ) else $error("push into full output stage");

    a_stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_metadata)
    ) else $error("output changed while stalled");

endmodule

//--- qm_pkg.sv
////////////////////////////////////////
// queue manager shared constants
// queue geometry and field widths
////////////////////////////////////////

package qm_pkg;

    ////////////////////////////////////////
    // queue geometry
    ////////////////////////////////////////

    localparam int num_groups       = 12;     // flow groups on the port
    localparam int num_classes      = 4;      // traffic classes, 3 is highest
    localparam int groups_per_class = 3;      // num_groups / num_classes
    localparam int group_depth      = 8;      // descriptors per group fifo

    ////////////////////////////////////////
    // field widths
    ////////////////////////////////////////

    localparam int time_width  = 59;          // eligibility time and local clock
    localparam int md_width    = 20;          // descriptor metadata
    localparam int group_width = 4;           // group number, 0..15 on the wire
    localparam int class_width = 2;           // class number
    localparam int count_width = 4;           // fill count 0..group_depth

    // A group g belongs to class (g % num_classes). Slot k of class c is
    // group c + k * num_classes, so class 1 owns groups 1, 5 and 9.

endpackage

//--- sim.f
qm_pkg.sv
qm_enqueue_decode.sv
qm_group_store.sv
qm_eligibility_sched.sv
qm_output_stage.sv
switch_qm.sv
qm_checker.sv
tb_switch_qm.sv

//--- switch_qm.sv
////////////////////////////////////////
// switch_qm top level
// decoder, group store, scheduler, output
////////////////////////////////////////

`timescale 1ns/1ns

module switch_qm import qm_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [time_width-1:0]  local_clock,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [group_width-1:0] in_group_id,
    input  logic [md_width-1:0]    in_metadata,
    input  logic [time_width-1:0]  in_elig_time,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [md_width-1:0]    out_metadata,
    output logic [group_width-1:0] out_group_id
);

    logic                                  wr_en;          // decoder to store
    logic [group_width-1:0]                wr_group;
    logic [md_width-1:0]                   wr_metadata;
    logic [time_width-1:0]                 wr_time;
    logic [num_groups-1:0]                 group_full;
    logic [num_groups-1:0]                 head_valid;     // store to scheduler
    logic [num_groups-1:0][md_width-1:0]   head_metadata;
    logic [num_groups-1:0][time_width-1:0] head_time;
    logic                                  pop_en;
    logic [group_width-1:0]                pop_group;
    logic                                  push_en;        // scheduler to output
    logic [md_width-1:0]                   push_metadata;
    logic [group_width-1:0]                push_group;
    logic                                  space_ok;

    qm_enqueue_decode u_decode (
        .clk, .reset,
        .in_valid, .in_group_id, .in_metadata, .in_elig_time,
        .group_full, .in_ready,
        .wr_en, .wr_group, .wr_metadata, .wr_time
    );

    qm_group_store u_store (
        .clk, .reset,
        .wr_en, .wr_group, .wr_metadata, .wr_time,
        .pop_en, .pop_group,
        .group_full, .head_valid, .head_metadata, .head_time
    );

    qm_eligibility_sched u_sched (
        .clk, .reset, .local_clock,
        .head_valid, .head_metadata, .head_time, .space_ok,
        .pop_en, .pop_group,
        .push_en, .push_metadata, .push_group
    );

    qm_output_stage u_out (
        .clk, .reset,
        .push_en, .push_metadata, .push_group,
        .out_ready, .space_ok,
        .out_valid, .out_metadata, .out_group_id
    );

endmodule

//--- tb_switch_qm.sv
////////////////////////////////////////
// switch_qm testbench
// clock, reset, stimulus, local clock
// and watchdog
////////////////////////////////////////

`timescale 1ns/1ns

module tb_switch_qm import qm_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int random_count = 40;
    localparam int total_sent   = 6 + 2 + 6 + 24 + random_count + 10;
    localparam int wait_limit   = 3000;   // cycles per single wait

    logic                   clk;
    logic                   reset;
    logic [time_width-1:0]  local_clock;
    logic                   in_valid;
    logic                   in_ready;
    logic [group_width-1:0] in_group_id;
    logic [md_width-1:0]    in_metadata;
    logic [time_width-1:0]  in_elig_time;
    logic                   out_valid;
    logic                   out_ready;
    logic [md_width-1:0]    out_metadata;
    logic [group_width-1:0] out_group_id;
    int                     chk_errors;
    int                     outputs_seen;
    int                     pending;
    int                     tb_errors;
    int                     errors_before;
    int                     expected_out;
    int                     fill [num_groups];
    int                     grp;
    integer                 seed;
    logic                   stall_rand;       // random out_ready while waiting

    switch_qm uut (
        .clk, .reset, .local_clock,
        .in_valid, .in_ready, .in_group_id, .in_metadata, .in_elig_time,
        .out_valid, .out_ready, .out_metadata, .out_group_id
    );

    qm_checker u_checker (
        .clk, .reset, .local_clock,
        .in_valid, .in_ready, .in_group_id, .in_metadata, .in_elig_time,
        .out_valid, .out_ready, .out_metadata, .out_group_id,
        .errors(chk_errors), .outputs_seen, .pending
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (total_sent * 200 + 1000) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", total_sent * 200 + 1000);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    // called on a falling edge
    task automatic drive_input(input int g, input logic [md_width-1:0] md,
                               input logic [time_width-1:0] tm);
        in_valid     = 1'b1;
        in_group_id  = group_width'(g);
        in_metadata  = md;
        in_elig_time = tm;
    endtask

    task automatic complete_transfer();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!in_ready && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("error at %0t: input for group %0d was never accepted", $time, in_group_id);
            tb_errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send(input int g, input logic [md_width-1:0] md,
                        input logic [time_width-1:0] tm);
        drive_input(g, md, tm);
        complete_transfer();
    endtask

    task automatic wait_outputs(input int count);
        int waited;
        waited = 0;
        expected_out += count;
        while (outputs_seen < expected_out && waited < wait_limit) begin
            @(negedge clk);
            if (stall_rand)
                out_ready = ($random(seed) & 1) != 0;
            waited++;
        end
        out_ready = 1'b1;
        if (outputs_seen < expected_out) begin
            $display("error at %0t: only %0d of %0d outputs arrived",
                     $time, outputs_seen, expected_out);
            tb_errors++;
        end
    endtask

    // nothing may leave for a while
    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        if (outputs_seen != expected_out) begin
            $display("FAIL %0t: %0d outputs seen, expected %0d", $time, outputs_seen, expected_out);
            tb_errors++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (pending != 0) begin
            $display("error at %0t: %0d descriptors never came out", $time, pending);
            tb_errors++;
        end
        $display("test %0d %s: %0d errors", num, name, chk_errors + tb_errors - errors_before);
        errors_before = chk_errors + tb_errors;
        local_clock   = '0;   // hold everything for the next load
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin
        seed         = 32'h1f60;
        reset        = 1'b1;
        local_clock  = '0;
        in_valid     = 1'b0;
        in_group_id  = '0;
        in_metadata  = '0;
        in_elig_time = '0;
        out_ready    = 1'b1;
        stall_rand   = 1'b0;
        tb_errors    = 0;
        errors_before = 0;
        expected_out = 0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        for (int i = 0; i < 6; i++)
            send(6, md_width'(32'h10000 + i), time_width'(10 * (i + 1)));
        local_clock = time_width'(100);
        wait_outputs(6);
        report_test(1, "order within a group");

        send(4, md_width'(32'h20001), time_width'(100));   // class 0
        send(3, md_width'(32'h20002), time_width'(300));   // class 3, held
        local_clock = time_width'(200);
        wait_outputs(1);
        expect_quiet(20);
        local_clock = time_width'(300);
        wait_outputs(1);
        report_test(2, "ineligible entries held");

        send(1, md_width'(32'h30001), time_width'(50));
        send(1, md_width'(32'h30002), time_width'(60));
        send(5, md_width'(32'h30003), time_width'(30));
        send(5, md_width'(32'h30004), time_width'(70));
        send(9, md_width'(32'h30005), time_width'(30));    // ties with group 5
        send(9, md_width'(32'h30006), time_width'(40));
        local_clock = time_width'(100);
        wait_outputs(6);
        report_test(3, "earliest eligible in class");

        for (int i = 0; i < 2 * num_groups; i++)
            send(i % num_groups, md_width'($random(seed)),
                 time_width'(1 + ($random(seed) & 255)));
        local_clock = '1;
        wait_outputs(2 * num_groups);
        report_test(4, "strict priority");

        for (int i = 0; i < num_groups; i++)
            fill[i] = 0;
        for (int i = 0; i < random_count; i++) begin
            grp = int'($unsigned($random(seed)) % num_groups);
            while (fill[grp] >= group_depth)
                grp = (grp + 1) % num_groups;   // never block on a full group
            fill[grp]++;
            send(grp, md_width'($random(seed)), time_width'(1 + ($random(seed) & 1023)));
        end
        local_clock = '1;
        stall_rand  = 1'b1;
        wait_outputs(random_count);
        stall_rand  = 1'b0;
        report_test(5, "back-pressure");

        for (int i = 0; i < group_depth; i++)
            send(2, md_width'(32'h60000 + i), time_width'(10 * (i + 1)));
        drive_input(2, md_width'(32'h60008), time_width'(90));
        repeat (6) begin
            @(posedge clk);
            if (in_ready) begin
                $display("FAIL %0t: in_ready high for a full group", $time);
                tb_errors++;
            end
        end
        @(negedge clk);
        local_clock = time_width'(1000);   // first pop frees a slot
        complete_transfer();
        send(13, md_width'(32'h6000d), time_width'(5));   // dropped by the decoder
        wait_outputs(group_depth + 1);
        expect_quiet(20);
        report_test(6, "full group and bad group number");

        $display("summary: 6 tests, %0d outputs checked, %0d errors",
                 outputs_seen, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
